/* verilog/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define XLEN   32
`define NREGS  32
`define REG_AW 5

// opcode fields of the 32-bit encoding
`define OPC6_MSB 31
`define OPC6_LSB 26
`define OPC4_MSB 25
`define OPC4_LSB 22
`define OPC2_MSB 21
`define OPC2_LSB 20
`define OPC5_MSB 19
`define OPC5_LSB 15

// register fields, each REG_AW wide
`define RD_LSB 0
`define RJ_LSB 5
`define RK_LSB 10

`endif

/* verilog/decode_pkg.sv */
`include "decode_params.svh"

package decode_pkg;

    typedef logic [`REG_AW-1:0] reg_addr_t;
    typedef logic [`XLEN-1:0]   word_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_kind_e;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } fetch_bus_t;

    // register file write port from writeback
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_write_t;

    // dest 0 means the stage writes nothing
    typedef struct packed {
        reg_addr_t dest;
        word_t     value;
    } fwd_src_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src_reg_is_rd;
        logic      reads_rj;
        logic      reads_rkd;
        logic      res_from_mem;
        logic      mem_we;
        logic      gr_we;
        reg_addr_t dest;
        br_kind_e  br_kind;
        word_t     imm;
        word_t     br_offs;
        logic      illegal;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     alu_src1;
        word_t     alu_src2;
        word_t     store_data;
        logic      res_from_mem;
        logic      mem_we;
        logic      gr_we;
        reg_addr_t dest;
        logic      illegal;
    } issue_bus_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_bus_t;

endpackage

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps
`include "decode_params.svh"

module inst_decoder
    import decode_pkg::*;
(
    input  word_t     inst,
    output ctrl_t     ctrl,
    output reg_addr_t rj,
    output reg_addr_t rkd
);

    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_addr_t   rd;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic is_3r;
    logic is_shift_imm;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_addi_w, inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_andi, inst_ori, inst_xori, inst_lu12i_w;
    logic inst_ld_w, inst_st_w;
    logic inst_beq, inst_bne, inst_blt, inst_bge;
    logic inst_b, inst_bl, inst_jirl;
    logic reg_alu;
    logic cond_br;
    logic need_ui12;
    logic legal;

    assign op6 = inst[`OPC6_MSB:`OPC6_LSB];
    assign op4 = inst[`OPC4_MSB:`OPC4_LSB];
    assign op2 = inst[`OPC2_MSB:`OPC2_LSB];
    assign op5 = inst[`OPC5_MSB:`OPC5_LSB];
    assign rd  = inst[`RD_LSB +: `REG_AW];
    assign rj  = inst[`RJ_LSB +: `REG_AW];
    assign rk  = inst[`RK_LSB +: `REG_AW];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};

    assign is_3r        = (op6 == 6'h00) && (op4 == 4'h0) && (op2 == 2'h1);
    assign is_shift_imm = (op6 == 6'h00) && (op4 == 4'h1) && (op2 == 2'h0);

    assign inst_add_w   = is_3r && (op5 == 5'h00);
    assign inst_sub_w   = is_3r && (op5 == 5'h02);
    assign inst_slt     = is_3r && (op5 == 5'h04);
    assign inst_sltu    = is_3r && (op5 == 5'h05);
    assign inst_nor     = is_3r && (op5 == 5'h08);
    assign inst_and     = is_3r && (op5 == 5'h09);
    assign inst_or      = is_3r && (op5 == 5'h0a);
    assign inst_xor     = is_3r && (op5 == 5'h0b);
    assign inst_slli_w  = is_shift_imm && (op5 == 5'h01);
    assign inst_srli_w  = is_shift_imm && (op5 == 5'h09);
    assign inst_srai_w  = is_shift_imm && (op5 == 5'h11);
    assign inst_addi_w  = (op6 == 6'h00) && (op4 == 4'ha);
    assign inst_andi    = (op6 == 6'h00) && (op4 == 4'hd);
    assign inst_ori     = (op6 == 6'h00) && (op4 == 4'he);
    assign inst_xori    = (op6 == 6'h00) && (op4 == 4'hf);
    assign inst_lu12i_w = (op6 == 6'h05) && !inst[25];
    assign inst_ld_w    = (op6 == 6'h0a) && (op4 == 4'h2);
    assign inst_st_w    = (op6 == 6'h0a) && (op4 == 4'h6);
    assign inst_jirl    = (op6 == 6'h13);
    assign inst_b       = (op6 == 6'h14);
    assign inst_bl      = (op6 == 6'h15);
    assign inst_beq     = (op6 == 6'h16);
    assign inst_bne     = (op6 == 6'h17);
    assign inst_blt     = (op6 == 6'h18);
    assign inst_bge     = (op6 == 6'h19);

    assign reg_alu   = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                     | inst_and | inst_or | inst_xor | inst_nor;
    assign cond_br   = inst_beq | inst_bne | inst_blt | inst_bge;
    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign legal     = reg_alu | is_shift_imm & (inst_slli_w | inst_srli_w | inst_srai_w)
                     | inst_addi_w | need_ui12 | inst_lu12i_w | inst_ld_w | inst_st_w
                     | cond_br | inst_b | inst_bl | inst_jirl;

    // stores and conditional branches read rd as their second source
    assign rkd = ctrl.src_reg_is_rd ? rd : rk;

    always_comb begin
        ctrl = '0;
        if (inst_sub_w) ctrl.alu_op = ALU_SUB;
        else if (inst_slt) ctrl.alu_op = ALU_SLT;
        else if (inst_sltu) ctrl.alu_op = ALU_SLTU;
        else if (inst_and | inst_andi) ctrl.alu_op = ALU_AND;
        else if (inst_or | inst_ori) ctrl.alu_op = ALU_OR;
        else if (inst_xor | inst_xori) ctrl.alu_op = ALU_XOR;
        else if (inst_nor) ctrl.alu_op = ALU_NOR;
        else if (inst_slli_w) ctrl.alu_op = ALU_SLL;
        else if (inst_srli_w) ctrl.alu_op = ALU_SRL;
        else if (inst_srai_w) ctrl.alu_op = ALU_SRA;
        else if (inst_lu12i_w) ctrl.alu_op = ALU_LUI;
        else ctrl.alu_op = ALU_ADD;

        if (inst_beq) ctrl.br_kind = BR_BEQ;
        else if (inst_bne) ctrl.br_kind = BR_BNE;
        else if (inst_blt) ctrl.br_kind = BR_BLT;
        else if (inst_bge) ctrl.br_kind = BR_BGE;
        else if (inst_b) ctrl.br_kind = BR_B;
        else if (inst_bl) ctrl.br_kind = BR_BL;
        else if (inst_jirl) ctrl.br_kind = BR_JIRL;
        else ctrl.br_kind = BR_NONE;

        ctrl.src1_is_pc    = inst_jirl | inst_bl;
        ctrl.src2_is_imm   = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                           | need_ui12 | inst_lu12i_w | inst_ld_w | inst_st_w
                           | inst_jirl | inst_bl;
        ctrl.src_reg_is_rd = inst_st_w | cond_br;
        ctrl.reads_rj      = legal & ~inst_b & ~inst_bl & ~inst_lu12i_w;
        ctrl.reads_rkd     = reg_alu | inst_st_w | cond_br;
        ctrl.res_from_mem  = inst_ld_w;
        ctrl.mem_we        = inst_st_w;
        ctrl.gr_we         = legal & ~inst_st_w & ~cond_br & ~inst_b;
        ctrl.dest          = inst_bl ? reg_addr_t'(1) : rd;
        ctrl.illegal       = ~legal;

        // link value pc+4 goes through the ALU
        if (inst_jirl | inst_bl) ctrl.imm = 32'h4;
        else if (need_ui12) ctrl.imm = {20'h0, i12};
        else if (inst_lu12i_w) ctrl.imm = {i20, 12'h0};
        else ctrl.imm = {{20{i12[11]}}, i12};

        if (inst_b | inst_bl) ctrl.br_offs = {{4{i26[25]}}, i26, 2'b00};
        else ctrl.br_offs = {{14{i16[15]}}, i16, 2'b00};
    end

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps
`include "decode_params.svh"

module regfile
    import decode_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    input  wb_write_t wb
);

    word_t mem [`NREGS];

    always_ff @(posedge clk) begin
        if (wb.we && (wb.addr != '0)) begin
            mem[wb.addr] <= wb.data;
        end
    end

    // r0 is hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

    // an enabled write needs a known address
    a_wb_addr_known: assert property (
        @(posedge clk) wb.we |-> !$isunknown(wb.addr)
    );

endmodule

/* verilog/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass
    import decode_pkg::*;
(
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  logic      reads1,
    input  logic      reads2,
    input  word_t     rdata1,
    input  word_t     rdata2,
    input  fwd_src_t  es_fwd,
    input  fwd_src_t  ms_fwd,
    input  fwd_src_t  ws_fwd,
    input  logic      es_is_load,
    output word_t     rj_value,
    output word_t     rkd_value,
    output logic      load_stall
);

    // youngest producer wins
    function automatic word_t pick(reg_addr_t addr, word_t rf_data,
                                   fwd_src_t es, fwd_src_t ms, fwd_src_t ws);
        word_t val;
        if (addr == '0) val = '0;
        else if (es.dest == addr) val = es.value;
        else if (ms.dest == addr) val = ms.value;
        else if (ws.dest == addr) val = ws.value;
        else val = rf_data;
        return val;
    endfunction

    assign rj_value  = pick(raddr1, rdata1, es_fwd, ms_fwd, ws_fwd);
    assign rkd_value = pick(raddr2, rdata2, es_fwd, ms_fwd, ws_fwd);

    always_comb begin
        // load data is not ready until memory stage
        load_stall = es_is_load && (es_fwd.dest != '0)
                   && ((reads1 && (raddr1 == es_fwd.dest))
                    || (reads2 && (raddr2 == es_fwd.dest)));
    end

endmodule

/* verilog/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit
    import decode_pkg::*;
(
    input  ctrl_t ctrl,
    input  word_t pc,
    input  word_t rj_value,
    input  word_t rkd_value,
    output logic  taken,
    output word_t target
);

    logic rj_eq_rd;
    logic rj_lt_rd;

    assign rj_eq_rd = (rj_value == rkd_value);
    assign rj_lt_rd = ($signed(rj_value) < $signed(rkd_value));

    always_comb begin
        case (ctrl.br_kind)
            BR_BEQ:  taken = rj_eq_rd;
            BR_BNE:  taken = !rj_eq_rd;
            BR_BLT:  taken = rj_lt_rd;
            BR_BGE:  taken = !rj_lt_rd;
            BR_B,
            BR_BL,
            BR_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative, everything else pc relative
    assign target = (ctrl.br_kind == BR_JIRL) ? (rj_value + ctrl.br_offs)
                                              : (pc + ctrl.br_offs);

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       fs_valid,
    input  fetch_bus_t fs_bus,
    output logic       ds_allowin,
    input  logic       es_allowin,
    output logic       ds_to_es_valid,
    output issue_bus_t ds_to_es_bus,
    output br_bus_t    br_bus,
    input  wb_write_t  wb_write,
    input  fwd_src_t   es_fwd,
    input  fwd_src_t   ms_fwd,
    input  fwd_src_t   ws_fwd,
    input  logic       es_is_load,
    input  logic       flush
);

    logic       ds_valid;
    logic       ds_ready_go;
    fetch_bus_t fs_bus_r;
    ctrl_t      ctrl;
    reg_addr_t  rj;
    reg_addr_t  rkd;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    word_t      rj_value;
    word_t      rkd_value;
    logic       load_stall;
    logic       br_taken;
    word_t      br_target;
    logic       br_cancel;

    inst_decoder i_inst_decoder (
        .inst (fs_bus_r.inst),
        .ctrl (ctrl),
        .rj   (rj),
        .rkd  (rkd)
    );

    regfile i_regfile (
        .clk    (clk),
        .raddr1 (rj),
        .raddr2 (rkd),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wb     (wb_write)
    );

    operand_bypass i_operand_bypass (
        .raddr1     (rj),
        .raddr2     (rkd),
        .reads1     (ctrl.reads_rj),
        .reads2     (ctrl.reads_rkd),
        .rdata1     (rf_rdata1),
        .rdata2     (rf_rdata2),
        .es_fwd     (es_fwd),
        .ms_fwd     (ms_fwd),
        .ws_fwd     (ws_fwd),
        .es_is_load (es_is_load),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .load_stall (load_stall)
    );

    branch_unit i_branch_unit (
        .ctrl      (ctrl),
        .pc        (fs_bus_r.pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .taken     (br_taken),
        .target    (br_target)
    );

    assign ds_ready_go    = !load_stall || flush;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go && !flush;
    assign br_cancel      = br_taken && ds_valid && ds_ready_go;

    assign br_bus.taken  = br_cancel;
    assign br_bus.target = br_target;

    // the slot after a taken branch is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (br_cancel || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            fs_bus_r <= fs_bus;
        end
    end

    always_comb begin
        ds_to_es_bus.pc           = fs_bus_r.pc;
        ds_to_es_bus.alu_op       = ctrl.alu_op;
        ds_to_es_bus.alu_src1     = ctrl.src1_is_pc ? fs_bus_r.pc : rj_value;
        ds_to_es_bus.alu_src2     = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
        ds_to_es_bus.store_data   = rkd_value;
        ds_to_es_bus.res_from_mem = ctrl.res_from_mem;
        ds_to_es_bus.mem_we       = ctrl.mem_we;
        ds_to_es_bus.gr_we        = ctrl.gr_we;
        ds_to_es_bus.dest         = ctrl.dest;
        ds_to_es_bus.illegal      = ctrl.illegal;
    end

    // record held under back-pressure must not change
    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
            ds_to_es_valid && !es_allowin |=> $stable(ds_to_es_bus)
    );

endmodule

/* testbench/tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage
    import decode_pkg::*;
();

    typedef enum logic [4:0] {
        K_ADD_W, K_SUB_W, K_SLT, K_SLTU, K_AND, K_OR, K_XOR, K_NOR,
        K_ADDI_W, K_SLLI_W, K_SRLI_W, K_SRAI_W, K_ANDI, K_ORI, K_XORI, K_LU12I_W,
        K_LD_W, K_ST_W, K_BEQ, K_BNE, K_BLT, K_BGE, K_B, K_BL, K_JIRL, K_ILLEGAL
    } op_kind_e;

    typedef struct packed {
        op_kind_e    kind;
        reg_addr_t   rd;
        reg_addr_t   rj;
        reg_addr_t   rk;
        logic [25:0] imm;
        word_t       pc;
        fwd_src_t    es;
        fwd_src_t    ms;
        fwd_src_t    ws;
        logic        load;
        logic        hold;
        logic        flush;
    } entry_t;

    logic       clk;
    logic       reset;
    logic       fs_valid;
    fetch_bus_t fs_bus;
    logic       ds_allowin;
    logic       es_allowin;
    logic       ds_to_es_valid;
    issue_bus_t ds_to_es_bus;
    br_bus_t    br_bus;
    wb_write_t  wb_write;
    fwd_src_t   es_fwd;
    fwd_src_t   ms_fwd;
    fwd_src_t   ws_fwd;
    logic       es_is_load;
    logic       flush;

    entry_t tests[$];
    word_t  regs [32];
    word_t  next_pc = 32'h1c00_0000;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    decode_stage i_decode_stage (
        .clk            (clk),
        .reset          (reset),
        .fs_valid       (fs_valid),
        .fs_bus         (fs_bus),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus),
        .wb_write       (wb_write),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_fwd         (ws_fwd),
        .es_is_load     (es_is_load),
        .flush          (flush)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "decode stage test stopped");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_run($sformatf("TIMEOUT: test did not finish within %0d cycles", cycle_limit));
        end
    end

    function automatic void add_op(op_kind_e k, int rd, int rj, int rk, int imm);
        entry_t e;
        e = '0;
        e.kind = k;
        e.rd = reg_addr_t'(rd);
        e.rj = reg_addr_t'(rj);
        e.rk = reg_addr_t'(rk);
        e.imm = imm[25:0];
        e.pc = next_pc;
        next_pc = next_pc + 32'h10;
        tests.push_back(e);
    endfunction

    function automatic void set_fwd(int ed, word_t ev, int md, word_t mv, int wd, word_t wv);
        entry_t e;
        e = tests.pop_back();
        e.es = {reg_addr_t'(ed), ev};
        e.ms = {reg_addr_t'(md), mv};
        e.ws = {reg_addr_t'(wd), wv};
        tests.push_back(e);
    endfunction

    function automatic void set_mode(logic load, logic hold, logic flush_it);
        entry_t e;
        e = tests.pop_back();
        e.load = load;
        e.hold = hold;
        e.flush = flush_it;
        tests.push_back(e);
    endfunction

    // LoongArch encodings of the kept subset
    function automatic word_t encode(entry_t e);
        word_t w;
        case (e.kind)
            K_ADD_W:   w = {17'h00020, e.rk, e.rj, e.rd};
            K_SUB_W:   w = {17'h00022, e.rk, e.rj, e.rd};
            K_SLT:     w = {17'h00024, e.rk, e.rj, e.rd};
            K_SLTU:    w = {17'h00025, e.rk, e.rj, e.rd};
            K_NOR:     w = {17'h00028, e.rk, e.rj, e.rd};
            K_AND:     w = {17'h00029, e.rk, e.rj, e.rd};
            K_OR:      w = {17'h0002a, e.rk, e.rj, e.rd};
            K_XOR:     w = {17'h0002b, e.rk, e.rj, e.rd};
            K_SLLI_W:  w = {17'h00081, e.rk, e.rj, e.rd};
            K_SRLI_W:  w = {17'h00089, e.rk, e.rj, e.rd};
            K_SRAI_W:  w = {17'h00091, e.rk, e.rj, e.rd};
            K_ADDI_W:  w = {10'h00a, e.imm[11:0], e.rj, e.rd};
            K_ANDI:    w = {10'h00d, e.imm[11:0], e.rj, e.rd};
            K_ORI:     w = {10'h00e, e.imm[11:0], e.rj, e.rd};
            K_XORI:    w = {10'h00f, e.imm[11:0], e.rj, e.rd};
            K_LD_W:    w = {10'h0a2, e.imm[11:0], e.rj, e.rd};
            K_ST_W:    w = {10'h0a6, e.imm[11:0], e.rj, e.rd};
            K_LU12I_W: w = {7'h0a, e.imm[19:0], e.rd};
            K_JIRL:    w = {6'h13, e.imm[15:0], e.rj, e.rd};
            K_B:       w = {6'h14, e.imm[15:0], e.imm[25:16]};
            K_BL:      w = {6'h15, e.imm[15:0], e.imm[25:16]};
            K_BEQ:     w = {6'h16, e.imm[15:0], e.rj, e.rd};
            K_BNE:     w = {6'h17, e.imm[15:0], e.rj, e.rd};
            K_BLT:     w = {6'h18, e.imm[15:0], e.rj, e.rd};
            K_BGE:     w = {6'h19, e.imm[15:0], e.rj, e.rd};
            default:   w = {6'h3f, e.imm[15:0], e.rj, e.rd};
        endcase
        return w;
    endfunction

    // execute over memory over writeback over register file
    function automatic word_t src_value(reg_addr_t a, entry_t e);
        if (a == '0) return '0;
        if (e.es.dest == a) return e.es.value;
        if (e.ms.dest == a) return e.ms.value;
        if (e.ws.dest == a) return e.ws.value;
        return regs[a];
    endfunction

    function automatic alu_op_e alu_of(op_kind_e k);
        case (k)
            K_SUB_W:           return ALU_SUB;
            K_SLT:             return ALU_SLT;
            K_SLTU:            return ALU_SLTU;
            K_AND, K_ANDI:     return ALU_AND;
            K_OR, K_ORI:       return ALU_OR;
            K_XOR, K_XORI:     return ALU_XOR;
            K_NOR:             return ALU_NOR;
            K_SLLI_W:          return ALU_SLL;
            K_SRLI_W:          return ALU_SRL;
            K_SRAI_W:          return ALU_SRA;
            K_LU12I_W:         return ALU_LUI;
            default:           return ALU_ADD;
        endcase
    endfunction

    function automatic issue_bus_t expect_issue(entry_t e, word_t inst);
        issue_bus_t x;
        reg_addr_t  a2;
        logic       is_cond;
        logic       use_imm;
        logic       link;
        word_t      imm;
        is_cond = e.kind inside {K_BEQ, K_BNE, K_BLT, K_BGE};
        link = e.kind inside {K_BL, K_JIRL};
        // stores and conditional branches take rd as second source
        a2 = (is_cond || e.kind == K_ST_W) ? inst[4:0] : inst[14:10];
        use_imm = link || e.kind inside {K_ADDI_W, K_SLLI_W, K_SRLI_W, K_SRAI_W,
                                         K_ANDI, K_ORI, K_XORI, K_LU12I_W, K_LD_W, K_ST_W};
        if (link) imm = 32'h4;
        else if (e.kind inside {K_ANDI, K_ORI, K_XORI}) imm = {20'h0, inst[21:10]};
        else if (e.kind == K_LU12I_W) imm = {inst[24:5], 12'h0};
        else imm = {{20{inst[21]}}, inst[21:10]};
        x.pc = e.pc;
        x.alu_op = alu_of(e.kind);
        x.alu_src1 = link ? e.pc : src_value(inst[9:5], e);
        x.alu_src2 = use_imm ? imm : src_value(a2, e);
        x.store_data = src_value(a2, e);
        x.res_from_mem = (e.kind == K_LD_W);
        x.mem_we = (e.kind == K_ST_W);
        x.gr_we = !(is_cond || e.kind inside {K_ST_W, K_B, K_ILLEGAL});
        x.dest = (e.kind == K_BL) ? reg_addr_t'(1) : inst[4:0];
        x.illegal = (e.kind == K_ILLEGAL);
        return x;
    endfunction

    function automatic br_bus_t expect_branch(entry_t e, word_t inst);
        br_bus_t b;
        word_t   v1;
        word_t   v2;
        word_t   offs;
        v1 = src_value(inst[9:5], e);
        v2 = src_value(inst[4:0], e);
        if (e.kind inside {K_B, K_BL}) offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        else offs = {{14{inst[25]}}, inst[25:10], 2'b00};
        case (e.kind)
            K_BEQ:             b.taken = (v1 == v2);
            K_BNE:             b.taken = (v1 != v2);
            K_BLT:             b.taken = ($signed(v1) < $signed(v2));
            K_BGE:             b.taken = ($signed(v1) >= $signed(v2));
            K_B, K_BL, K_JIRL: b.taken = 1'b1;
            default:           b.taken = 1'b0;
        endcase
        b.target = (e.kind == K_JIRL) ? v1 + offs : e.pc + offs;
        return b;
    endfunction

    task automatic check_issue(input issue_bus_t got, input issue_bus_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s issue record got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_branch(input br_bus_t got, input br_bus_t exp, input string what);
        // target only matters when the branch is taken
        if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
            stop_run($sformatf("MISMATCH at %0t: %s branch got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic preload_regs();
        wb_write_t w;
        regs[0] = '0;
        for (int i = 1; i < 32; i++) begin
            @(posedge clk);
            regs[i] = $urandom();
            w.we = 1'b1;
            w.addr = reg_addr_t'(i);
            w.data = regs[i];
            wb_write <= w;
        end
        // r0 must stay zero
        @(posedge clk);
        w.addr = '0;
        w.data = 32'hffff_ffff;
        wb_write <= w;
        @(posedge clk);
        wb_write <= '0;
    endtask

    task automatic run_entry(input entry_t e, input int idx);
        word_t      inst;
        issue_bus_t exp_issue;
        br_bus_t    exp_br;
        string      tag;
        inst = encode(e);
        exp_issue = expect_issue(e, inst);
        exp_br = expect_branch(e, inst);
        tag = $sformatf("entry %0d", idx);
        @(posedge clk);
        fs_valid <= 1'b1;
        fs_bus <= {inst, e.pc};
        es_fwd <= e.es;
        ms_fwd <= e.ms;
        ws_fwd <= e.ws;
        es_is_load <= e.load;
        es_allowin <= !e.hold;
        @(negedge clk);
        while (!ds_allowin) @(negedge clk);
        @(posedge clk);
        fs_valid <= 1'b0;
        flush <= e.flush;
        if (exp_br.taken || e.flush) begin
            // next fetch, must be dropped
            fs_valid <= 1'b1;
            fs_bus <= {inst, e.pc + 32'h4};
        end
        if (e.load) begin
            repeat (2) begin
                @(negedge clk);
                check_flag(ds_to_es_valid, 1'b0, {tag, " valid during load stall"});
                check_flag(ds_allowin, 1'b0, {tag, " allowin during load stall"});
            end
            @(posedge clk);
            es_is_load <= 1'b0;
        end
        @(negedge clk);
        if (e.flush) begin
            check_flag(ds_to_es_valid, 1'b0, {tag, " valid under flush"});
            @(posedge clk);
            flush <= 1'b0;
            fs_valid <= 1'b0;
            @(negedge clk);
            check_flag(ds_to_es_valid, 1'b0, {tag, " valid after flush"});
        end else begin
            check_flag(ds_to_es_valid, 1'b1, {tag, " valid"});
            check_issue(ds_to_es_bus, exp_issue, tag);
            check_branch(br_bus, exp_br, tag);
            if (e.hold) begin
                repeat (3) begin
                    @(negedge clk);
                    check_flag(ds_allowin, 1'b0, {tag, " allowin under back-pressure"});
                    check_issue(ds_to_es_bus, exp_issue, {tag, " held"});
                end
                @(posedge clk);
                es_allowin <= 1'b1;
                @(negedge clk);
                check_flag(ds_to_es_valid, 1'b1, {tag, " valid after release"});
            end
            @(posedge clk);
            fs_valid <= 1'b0;
            @(negedge clk);
            check_flag(ds_to_es_valid, 1'b0, {tag, " valid after issue"});
        end
    endtask

    task automatic build_tests();
        add_op(K_ADD_W, 3, 1, 2, 0);
        add_op(K_SUB_W, 4, 5, 6, 0);
        add_op(K_SLT, 7, 8, 9, 0);
        add_op(K_SLTU, 10, 11, 12, 0);
        add_op(K_AND, 13, 14, 15, 0);
        add_op(K_OR, 16, 17, 18, 0);
        add_op(K_XOR, 19, 20, 21, 0);
        add_op(K_NOR, 22, 23, 24, 0);
        add_op(K_ADDI_W, 25, 26, 0, 'h801);
        add_op(K_SLLI_W, 27, 28, 3, 0);
        add_op(K_SRLI_W, 29, 30, 31, 0);
        add_op(K_SRAI_W, 31, 1, 7, 0);
        add_op(K_ANDI, 2, 3, 0, 'hf0f);
        add_op(K_ORI, 4, 5, 0, 'h800);
        add_op(K_XORI, 6, 7, 0, 'h123);
        add_op(K_LU12I_W, 8, 0, 0, 'hfedcb);
        add_op(K_LD_W, 9, 10, 0, 'hffc);
        add_op(K_ST_W, 11, 12, 0, 'h010);
        // bypass priority
        add_op(K_ADD_W, 3, 5, 6, 0);
        set_fwd(5, 32'h1111_0001, 5, 32'h2222_0002, 6, 32'h3333_0003);
        add_op(K_SUB_W, 3, 7, 8, 0);
        set_fwd(0, 32'hdead_beef, 7, 32'h4444_0004, 7, 32'h5555_0005);
        add_op(K_ADD_W, 3, 0, 9, 0);
        set_fwd(0, 32'hdead_beef, 0, 32'hfeed_f00d, 9, 32'h6666_0006);
        // load-use
        add_op(K_ADD_W, 3, 5, 6, 0);
        set_fwd(6, 32'h7777_0007, 0, 0, 0, 0);
        set_mode(1'b1, 1'b0, 1'b0);
        add_op(K_ST_W, 9, 10, 0, 'h004);
        set_fwd(9, 32'h8888_0008, 0, 0, 0, 0);
        set_mode(1'b1, 1'b0, 1'b0);
        // branches, both outcomes
        add_op(K_BEQ, 5, 5, 0, 'h0010);
        add_op(K_BEQ, 6, 5, 0, 'h0010);
        set_fwd(5, 32'h1, 6, 32'h2, 0, 0);
        add_op(K_BNE, 5, 5, 0, 'h0020);
        add_op(K_BNE, 6, 5, 0, 'hfff8);
        set_fwd(5, 32'h1, 6, 32'h2, 0, 0);
        add_op(K_BLT, 6, 5, 0, 'h0040);
        set_fwd(5, 32'hffff_fffb, 6, 32'h3, 0, 0);
        add_op(K_BLT, 5, 6, 0, 'h0040);
        set_fwd(5, 32'hffff_fffb, 6, 32'h3, 0, 0);
        add_op(K_BGE, 6, 5, 0, 'h0080);
        set_fwd(5, 32'hffff_fffb, 6, 32'h3, 0, 0);
        add_op(K_BGE, 5, 6, 0, 'hff00);
        set_fwd(5, 32'hffff_fffb, 6, 32'h3, 0, 0);
        add_op(K_B, 0, 0, 0, 'h3fffffc);
        add_op(K_BL, 0, 0, 0, 'h0001234);
        add_op(K_JIRL, 1, 7, 0, 'h0003);
        set_fwd(0, 0, 0, 0, 7, 32'h1c00_1000);
        // back-pressure and flush
        add_op(K_OR, 3, 4, 5, 0);
        set_mode(1'b0, 1'b1, 1'b0);
        add_op(K_ADDI_W, 6, 7, 0, 'h005);
        set_mode(1'b0, 1'b0, 1'b1);
        add_op(K_ILLEGAL, 3, 4, 0, 'habcd);
    endtask

    initial begin
        reset <= 1'b1;
        fs_valid <= 1'b0;
        fs_bus <= '0;
        es_allowin <= 1'b1;
        wb_write <= '0;
        es_fwd <= '0;
        ms_fwd <= '0;
        ws_fwd <= '0;
        es_is_load <= 1'b0;
        flush <= 1'b0;
        void'($urandom(32'ha054_85d4));
        build_tests();
        cycle_limit = 20 * tests.size() + 100;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        preload_regs();
        foreach (tests[i]) begin
            run_entry(tests[i], i);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* list.f */
+incdir+verilog
verilog/decode_pkg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_bypass.sv
verilog/branch_unit.sv
verilog/decode_stage.sv
testbench/tb_decode_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

{ verilator --binary --timing --assert \
    --top-module tb_decode_stage \
    -f list.f \
    -o sim_decode \
    && ./obj_dir/sim_decode; } > sim.log 2>&1

grep -qx "Done: no errors" sim.log \
    && echo "simulation passed, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }
